/* Makefile */
# Verilator build and run for the command splicer testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/cmd_holding.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_holding (
    input  wire logic                                    sysclk_i,
    input  wire logic                                    reset_i,
    input  wire logic                                    sync_i,
    // local mode1 stream
    input  wire logic                                    mode1_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0]  mode1_tdata_i,
    input  wire rackbus_pkg::mode1type_e                 mode1_tuser_i,
    // firmware upload bytes and end mark request
    input  wire logic                                    fw_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0]  fw_tdata_i,
    input  wire logic                                    fw_mark_i,
    // local run commands
    input  wire logic                                    runcmd_tvalid_i,
    input  wire rackbus_pkg::runcmd_e                    runcmd_tdata_i,
    splice_hold_if.holder                                hold_o
);
    import rackbus_pkg::*;

    // position inside the current frame
    logic [PHASE_BITS-1:0] phase;
    logic [PHASE_BITS-1:0] phase_nxt;

    // sync realigns so that the following cycle is phase 1
    always_comb begin
        if (sync_i) begin
            phase_nxt = PHASE_BITS'(1);
        end else if (phase == PHASE_BITS'(FRAME_LEN - 1)) begin
            phase_nxt = '0;
        end else begin
            phase_nxt = phase + PHASE_BITS'(1);
        end
    end

    // phase counter and strobes
    // strobes come from the next phase so they line up exactly with
    // phase 6 and 7 even right after a sync realignment
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            phase             <= '0;
            hold_o.precapture <= 1'b0;
            hold_o.capture    <= 1'b0;
        end else begin
            phase             <= phase_nxt;
            hold_o.precapture <= (phase_nxt == PHASE_BITS'(PRECAPTURE_PHASE));
            hold_o.capture    <= (phase_nxt == PHASE_BITS'(CAPTURE_PHASE));
        end
    end

    // holding registers, reloaded every frame at the end of precapture
    // a value that got displaced by a higher source just gets
    // sampled again next frame, since its valid stays up
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            hold_o.mode1data_hold <= MODE1_NOOP;
            hold_o.mode1type_hold <= MODE1_SPECIAL;
            hold_o.hold_mode1     <= 1'b0;
            hold_o.hold_mark      <= 1'b0;
            hold_o.hold_fwu       <= 1'b0;
            hold_o.runcmd_hold    <= RUNCMD_NOOP;
            hold_o.hold_runcmd    <= 1'b0;
        end else if (hold_o.precapture) begin
            // mode1 field priority: mode1 stream, mark, fw byte, noop
            if (mode1_tvalid_i) begin
                hold_o.mode1data_hold <= mode1_tdata_i;
                hold_o.mode1type_hold <= mode1_tuser_i;
            end else if (fw_mark_i) begin
                hold_o.mode1data_hold <= MODE1_MARK_FWU;
                hold_o.mode1type_hold <= MODE1_SPECIAL;
            end else if (fw_tvalid_i) begin
                hold_o.mode1data_hold <= fw_tdata_i;
                hold_o.mode1type_hold <= MODE1_FWU;
            end else begin
                hold_o.mode1data_hold <= MODE1_NOOP;
                hold_o.mode1type_hold <= MODE1_SPECIAL;
            end

            // exclusive source flags, same priority as above
            hold_o.hold_mode1 <= mode1_tvalid_i;
            hold_o.hold_mark  <= fw_mark_i && !mode1_tvalid_i;
            hold_o.hold_fwu   <= fw_tvalid_i && !fw_mark_i && !mode1_tvalid_i;

            // runcmd has only one local source
            if (runcmd_tvalid_i) begin
                hold_o.runcmd_hold <= runcmd_tdata_i;
            end else begin
                hold_o.runcmd_hold <= RUNCMD_NOOP;
            end
            hold_o.hold_runcmd <= runcmd_tvalid_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/cmd_splice.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_splice (
    input  wire logic                               sysclk_i,
    input  wire logic                               reset_i,
    // remote master word
    input  wire logic [rackbus_pkg::CMD_BITS-1:0]   command_i,
    input  wire logic                               command_locked_i,
    // local trigger, no ready: goes out whenever remote leaves room
    input  wire logic                               trig_tvalid_i,
    input  wire logic [rackbus_pkg::TRIG_BITS-1:0]  trig_tdata_i,
    // local pps
    input  wire logic                               tfio_pps_i,
    input  wire logic                               use_tfio_pps_i,
    splice_hold_if.splicer                          hold_i,
    output logic      [rackbus_pkg::CMD_BITS-1:0]   spliced_o,
    // one-cycle acknowledges, in the cycle after capture
    output logic                                    mode1_tready_o,
    output logic                                    fw_tready_o,
    output logic                                    fw_marked_o,
    output logic                                    runcmd_tready_o
);
    import rackbus_pkg::*;

    // remote fields
    logic                      remote_ignore;
    logic                      remote_pps;
    runcmd_e                   remote_runcmd;
    mode1type_e                remote_mode1type;
    logic [MODE1DATA_BITS-1:0] remote_mode1data;
    logic                      remote_trigvalid;
    logic [TRIG_BITS-1:0]      remote_trig;

    // field ownership
    logic                      mode1_free;
    logic                      runcmd_free;
    logic                      turf_trig_valid;
    logic                      turf_pps;

    // local pps, live or seen earlier this frame
    logic                      pps_seen;
    logic                      tfio_pps;
    logic                      local_pending;

    assign remote_ignore    = command_i[IGNORE_BIT];
    assign remote_pps       = command_i[PPS_BIT];
    assign remote_runcmd    = runcmd_e'(command_i[RUNCMD_LSB +: RUNCMD_BITS]);
    assign remote_mode1type = mode1type_e'(command_i[MODE1TYPE_LSB +: MODE1TYPE_BITS]);
    assign remote_mode1data = command_i[MODE1DATA_LSB +: MODE1DATA_BITS];
    assign remote_trigvalid = command_i[TRIGVALID_BIT];
    assign remote_trig      = command_i[TRIG_LSB +: TRIG_BITS];

    // mode1 is free when unlocked, ignored, or the type/data pair
    // differs from SPECIAL/NOOP
    // note the inverted sense: an idle remote SPECIAL/NOOP counts as busy
    assign mode1_free = !command_locked_i || remote_ignore ||
                        (remote_mode1type != MODE1_SPECIAL) ||
                        (remote_mode1data != MODE1_NOOP);

    // runcmd is free unless a locked, live remote runcmd is present
    assign runcmd_free = !command_locked_i || remote_ignore ||
                         (remote_runcmd == RUNCMD_NOOP);

    // remote trigger has the bottom half whenever it is valid
    assign turf_trig_valid = command_locked_i && remote_trigvalid;

    // pps source select
    assign turf_pps = remote_pps && command_locked_i && !remote_ignore;
    assign tfio_pps = tfio_pps_i || pps_seen;

    // anything local that has to make it out this frame
    assign local_pending = hold_i.hold_mode1 || hold_i.hold_fwu || hold_i.hold_mark ||
                           hold_i.hold_runcmd || (tfio_pps && use_tfio_pps_i);

    // word assembly, reserved bits stay zero
    always_comb begin
        spliced_o = '0;
        spliced_o[IGNORE_BIT] = (remote_ignore || !command_locked_i) && !local_pending;
        spliced_o[PPS_BIT]    = use_tfio_pps_i ? tfio_pps : turf_pps;
        spliced_o[RUNCMD_LSB +: RUNCMD_BITS] =
            runcmd_free ? hold_i.runcmd_hold : remote_runcmd;
        spliced_o[MODE1TYPE_LSB +: MODE1TYPE_BITS] =
            mode1_free ? hold_i.mode1type_hold : remote_mode1type;
        spliced_o[MODE1DATA_LSB +: MODE1DATA_BITS] =
            mode1_free ? hold_i.mode1data_hold : remote_mode1data;
        spliced_o[TRIGVALID_BIT] = turf_trig_valid || trig_tvalid_i;
        spliced_o[TRIG_LSB +: TRIG_BITS] = turf_trig_valid ? remote_trig : trig_tdata_i;
    end

    // pps latch, a pulse anywhere in the frame survives to capture
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            pps_seen <= 1'b0;
        end else if (hold_i.capture) begin
            pps_seen <= 1'b0;
        end else if (tfio_pps_i) begin
            pps_seen <= 1'b1;
        end
    end

    // acknowledge only what actually went out at capture
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            mode1_tready_o  <= 1'b0;
            fw_tready_o     <= 1'b0;
            fw_marked_o     <= 1'b0;
            runcmd_tready_o <= 1'b0;
        end else begin
            mode1_tready_o  <= hold_i.capture && hold_i.hold_mode1 && mode1_free;
            fw_tready_o     <= hold_i.capture && hold_i.hold_fwu && mode1_free;
            fw_marked_o     <= hold_i.capture && hold_i.hold_mark && mode1_free;
            runcmd_tready_o <= hold_i.capture && hold_i.hold_runcmd && runcmd_free;
        end
    end

endmodule

`default_nettype wire

/* hdl/rackbus_pkg.sv */
`default_nettype none

package rackbus_pkg;

    // full command word width
    localparam int CMD_BITS = 32;

    // frame timing: one command word per 8 sysclk cycles
    localparam int FRAME_LEN        = 8;
    localparam int PHASE_BITS       = $clog2(FRAME_LEN);
    // local values get sampled here
    localparam int PRECAPTURE_PHASE = 6;
    // spliced word goes out here
    localparam int CAPTURE_PHASE    = 7;

    // field widths
    localparam int RUNCMD_BITS    = 2;
    localparam int MODE1TYPE_BITS = 2;
    localparam int MODE1DATA_BITS = 8;
    localparam int TRIG_BITS      = 15;

    // command word layout
    //   31     ignore
    //   30     pps
    //   29:28  runcmd
    //   27:26  mode1 type
    //   25:18  mode1 data
    //   17:16  reserved, always zero
    //   15     trigger valid
    //   14:0   trigger
    localparam int IGNORE_BIT    = 31;
    localparam int PPS_BIT       = 30;
    localparam int RUNCMD_LSB    = 28;
    localparam int MODE1TYPE_LSB = 26;
    localparam int MODE1DATA_LSB = 18;
    localparam int TRIGVALID_BIT = 15;
    localparam int TRIG_LSB      = 0;

    // run commands
    typedef enum logic [RUNCMD_BITS-1:0] {
        RUNCMD_NOOP  = 2'd0,
        RUNCMD_SYNC  = 2'd1,
        RUNCMD_RESET = 2'd2,
        RUNCMD_STOP  = 2'd3
    } runcmd_e;

    // mode1 data types
    typedef enum logic [MODE1TYPE_BITS-1:0] {
        MODE1_SPECIAL = 2'd0,
        MODE1_FWU     = 2'd1,
        MODE1_DATA    = 2'd2,
        MODE1_CTRL    = 2'd3
    } mode1type_e;

    // special codes, only meaningful with MODE1_SPECIAL
    localparam logic [MODE1DATA_BITS-1:0] MODE1_NOOP     = 8'h00;
    // end-of-upload marker for the firmware stream
    localparam logic [MODE1DATA_BITS-1:0] MODE1_MARK_FWU = 8'h01;

endpackage

`default_nettype wire

/* hdl/rackbus_splice_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rackbus_splice_top (
    input  wire logic                                     sysclk_i,
    input  wire logic                                     reset_i,
    input  wire logic                                     sync_i,
    // remote master word
    input  wire logic [rackbus_pkg::CMD_BITS-1:0]         command_i,
    input  wire logic                                     command_locked_i,
    // mode1 stream
    input  wire logic                                     mode1_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0]   mode1_tdata_i,
    input  wire logic [rackbus_pkg::MODE1TYPE_BITS-1:0]   mode1_tuser_i,
    output logic                                          mode1_tready_o,
    // firmware upload
    input  wire logic                                     fw_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0]   fw_tdata_i,
    output logic                                          fw_tready_o,
    input  wire logic                                     fw_mark_i,
    output logic                                          fw_marked_o,
    // run commands
    input  wire logic                                     runcmd_tvalid_i,
    input  wire logic [rackbus_pkg::RUNCMD_BITS-1:0]      runcmd_tdata_i,
    output logic                                          runcmd_tready_o,
    // triggers
    input  wire logic                                     trig_tvalid_i,
    input  wire logic [rackbus_pkg::TRIG_BITS-1:0]        trig_tdata_i,
    // pps
    input  wire logic                                     tfio_pps_i,
    input  wire logic                                     use_tfio_pps_i,
    // merged word
    output logic      [rackbus_pkg::CMD_BITS-1:0]         spliced_o
);
    import rackbus_pkg::*;

    // held values and strobes between the two halves
    splice_hold_if hold_bus ();

    // frame timing and local sampling
    cmd_holding u_hold (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .sync_i          (sync_i),
        .mode1_tvalid_i  (mode1_tvalid_i),
        .mode1_tdata_i   (mode1_tdata_i),
        .mode1_tuser_i   (mode1type_e'(mode1_tuser_i)),
        .fw_tvalid_i     (fw_tvalid_i),
        .fw_tdata_i      (fw_tdata_i),
        .fw_mark_i       (fw_mark_i),
        .runcmd_tvalid_i (runcmd_tvalid_i),
        .runcmd_tdata_i  (runcmd_e'(runcmd_tdata_i)),
        .hold_o          (hold_bus.holder)
    );

    // merge with the remote word
    cmd_splice u_splice (
        .sysclk_i         (sysclk_i),
        .reset_i          (reset_i),
        .command_i        (command_i),
        .command_locked_i (command_locked_i),
        .trig_tvalid_i    (trig_tvalid_i),
        .trig_tdata_i     (trig_tdata_i),
        .tfio_pps_i       (tfio_pps_i),
        .use_tfio_pps_i   (use_tfio_pps_i),
        .hold_i           (hold_bus.splicer),
        .spliced_o        (spliced_o),
        .mode1_tready_o   (mode1_tready_o),
        .fw_tready_o      (fw_tready_o),
        .fw_marked_o      (fw_marked_o),
        .runcmd_tready_o  (runcmd_tready_o)
    );

endmodule

`default_nettype wire

/* hdl/splice_hold_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface splice_hold_if;
    import rackbus_pkg::*;

    // frame strobes, registered in the holding block
    logic                      precapture;
    logic                      capture;

    // held mode1 field, always a valid type/data pair
    logic [MODE1DATA_BITS-1:0] mode1data_hold;
    mode1type_e                mode1type_hold;
    // which source filled the mode1 hold, at most one set
    logic                      hold_mode1;
    logic                      hold_fwu;
    logic                      hold_mark;

    // held run command, NOOP when nothing local
    runcmd_e                   runcmd_hold;
    logic                      hold_runcmd;

    modport holder (
        output precapture, capture,
        output mode1data_hold, mode1type_hold,
        output hold_mode1, hold_fwu, hold_mark,
        output runcmd_hold, hold_runcmd
    );

    modport splicer (
        input precapture, capture,
        input mode1data_hold, mode1type_hold,
        input hold_mode1, hold_fwu, hold_mark,
        input runcmd_hold, hold_runcmd
    );

endinterface

`default_nettype wire

/* tb.f */
hdl/rackbus_pkg.sv
hdl/splice_hold_if.sv
hdl/cmd_holding.sv
hdl/cmd_splice.sv
hdl/rackbus_splice_top.sv
testbench/splice_checker.sv
testbench/splice_monitor.sv
testbench/tb_top.sv

/* testbench/splice_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module splice_checker (
    input  wire logic                             sysclk_i,
    input  wire logic                             reset_i,
    input  wire logic                             capture_i,
    input  wire logic                             mode1_tready_i,
    input  wire logic                             fw_tready_i,
    input  wire logic                             fw_marked_i,
    input  wire logic                             runcmd_tready_i,
    input  wire logic [rackbus_pkg::CMD_BITS-1:0] spliced_i
);
    import rackbus_pkg::*;

    // all acknowledges with the mode1 field owners in the upper three bits
    logic [3:0] acks;
    // failed assertions so far
    int         fail_count = 0;

    assign acks = {mode1_tready_i, fw_tready_i, fw_marked_i, runcmd_tready_i};

    // an acknowledge is a single-cycle pulse
    a_ack_single: assert property (@(posedge sysclk_i) disable iff (reset_i)
        (|acks) |=> !(|acks))
        else begin
            fail_count++;
            $error("acknowledge held for more than one cycle");
        end

    // and it only follows a capture cycle
    a_ack_after_capture: assert property (@(posedge sysclk_i) disable iff (reset_i)
        (|acks) |-> $past(capture_i))
        else begin
            fail_count++;
            $error("acknowledge outside the cycle after capture");
        end

    // only one source can own the mode1 field per frame
    a_mode1_owner: assert property (@(posedge sysclk_i) disable iff (reset_i)
        $onehot0(acks[3:1]))
        else begin
            fail_count++;
            $error("more than one mode1 field acknowledge at once");
        end

    // bits 17:16 sit just below the mode1 data field
    a_reserved_zero: assert property (@(posedge sysclk_i)
        spliced_i[MODE1DATA_LSB-1 -: 2] == 2'b00)
        else begin
            fail_count++;
            $error("reserved bits of the spliced word not zero");
        end

endmodule

`default_nettype wire

/* testbench/splice_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module splice_monitor (
    input  wire logic                                   sysclk_i,
    input  wire logic                                   reset_i,
    input  wire logic                                   sync_i,
    input  wire logic [rackbus_pkg::CMD_BITS-1:0]       command_i,
    input  wire logic                                   command_locked_i,
    input  wire logic                                   mode1_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0] mode1_tdata_i,
    input  wire logic [rackbus_pkg::MODE1TYPE_BITS-1:0] mode1_tuser_i,
    input  wire logic                                   fw_tvalid_i,
    input  wire logic [rackbus_pkg::MODE1DATA_BITS-1:0] fw_tdata_i,
    input  wire logic                                   fw_mark_i,
    input  wire logic                                   runcmd_tvalid_i,
    input  wire logic [rackbus_pkg::RUNCMD_BITS-1:0]    runcmd_tdata_i,
    input  wire logic                                   trig_tvalid_i,
    input  wire logic [rackbus_pkg::TRIG_BITS-1:0]      trig_tdata_i,
    input  wire logic                                   tfio_pps_i,
    input  wire logic                                   use_tfio_pps_i,
    // DUT outputs
    input  wire logic [rackbus_pkg::CMD_BITS-1:0]       spliced_i,
    input  wire logic                                   mode1_tready_i,
    input  wire logic                                   fw_tready_i,
    input  wire logic                                   fw_marked_i,
    input  wire logic                                   runcmd_tready_i,
    output int                                          errors_o,
    output int                                          captures_o
);
    import rackbus_pkg::*;

    // frame position of the cycle that ends at the coming edge
    int                        phase;
    // expected holding state
    logic [MODE1TYPE_BITS-1:0] h_type;
    logic [MODE1DATA_BITS-1:0] h_data;
    logic [RUNCMD_BITS-1:0]    h_runcmd;
    logic                      h_mode1;
    logic                      h_mark;
    logic                      h_fwu;
    logic                      h_run;
    // local pps seen since the last capture
    logic                      pps_seen;
    logic                      pps_now;
    logic                      pending;
    logic [CMD_BITS-1:0]       exp_word;
    // order is mode1, fw, marked, runcmd
    logic [3:0]                acks;
    logic [3:0]                exp_acks;

    // remote SPECIAL/NOOP blocks the field, anything else leaves it open
    function automatic logic mode1_is_free(input logic [CMD_BITS-1:0] cmd,
                                           input logic locked);
        return !locked || cmd[IGNORE_BIT] ||
               (cmd[MODE1TYPE_LSB +: MODE1TYPE_BITS] != MODE1_SPECIAL) ||
               (cmd[MODE1DATA_LSB +: MODE1DATA_BITS] != MODE1_NOOP);
    endfunction

    function automatic logic runcmd_is_free(input logic [CMD_BITS-1:0] cmd,
                                            input logic locked);
        return !locked || cmd[IGNORE_BIT] ||
               (cmd[RUNCMD_LSB +: RUNCMD_BITS] == RUNCMD_NOOP);
    endfunction

    // reference packing of the word that goes out at capture
    function automatic logic [CMD_BITS-1:0] expected_word(
        input logic [CMD_BITS-1:0]       cmd,
        input logic                      locked,
        input logic [MODE1TYPE_BITS-1:0] m_type,
        input logic [MODE1DATA_BITS-1:0] m_data,
        input logic [RUNCMD_BITS-1:0]    run,
        input logic                      local_pending,
        input logic                      trig_v,
        input logic [TRIG_BITS-1:0]      trig_d,
        input logic                      pps_local,
        input logic                      use_local
    );
        logic [CMD_BITS-1:0] w;
        logic                remote_trig;
        w = '0;
        remote_trig = locked && cmd[TRIGVALID_BIT];
        w[IGNORE_BIT] = (cmd[IGNORE_BIT] || !locked) && !local_pending;
        w[PPS_BIT] = use_local ? pps_local : (cmd[PPS_BIT] && locked && !cmd[IGNORE_BIT]);
        w[RUNCMD_LSB +: RUNCMD_BITS] =
            runcmd_is_free(cmd, locked) ? run : cmd[RUNCMD_LSB +: RUNCMD_BITS];
        if (mode1_is_free(cmd, locked)) begin
            w[MODE1TYPE_LSB +: MODE1TYPE_BITS] = m_type;
            w[MODE1DATA_LSB +: MODE1DATA_BITS] = m_data;
        end else begin
            w[MODE1TYPE_LSB +: MODE1TYPE_BITS] = cmd[MODE1TYPE_LSB +: MODE1TYPE_BITS];
            w[MODE1DATA_LSB +: MODE1DATA_BITS] = cmd[MODE1DATA_LSB +: MODE1DATA_BITS];
        end
        // a locked remote trigger owns the whole trigger field
        w[TRIGVALID_BIT] = remote_trig || trig_v;
        w[TRIG_LSB +: TRIG_BITS] = remote_trig ? cmd[TRIG_LSB +: TRIG_BITS] : trig_d;
        return w;
    endfunction

    always @(posedge sysclk_i) begin
        if (reset_i) begin
            phase = 0;
            {h_mode1, h_mark, h_fwu, h_run} = 4'b0000;
            h_type = MODE1_SPECIAL;
            h_data = MODE1_NOOP;
            h_runcmd = RUNCMD_NOOP;
            pps_seen = 1'b0;
            exp_acks = '0;
            errors_o = 0;
            captures_o = 0;
        end else begin
            // acknowledges of the cycle that just ended
            acks = {mode1_tready_i, fw_tready_i, fw_marked_i, runcmd_tready_i};
            if (acks !== exp_acks) begin
                errors_o++;
                $display("mismatch at %0t: acknowledges %b, expected %b",
                         $time, acks, exp_acks);
            end
            exp_acks = '0;
            // sample the local sources, mode1 stream first, then mark, then fw
            if (phase == PRECAPTURE_PHASE) begin
                h_mode1 = mode1_tvalid_i;
                h_mark = fw_mark_i && !mode1_tvalid_i;
                h_fwu = fw_tvalid_i && !fw_mark_i && !mode1_tvalid_i;
                h_type = mode1_tvalid_i ? mode1_tuser_i :
                         h_fwu ? MODE1_FWU : MODE1_SPECIAL;
                h_data = mode1_tvalid_i ? mode1_tdata_i :
                         h_mark ? MODE1_MARK_FWU : h_fwu ? fw_tdata_i : MODE1_NOOP;
                h_run = runcmd_tvalid_i;
                h_runcmd = runcmd_tvalid_i ? runcmd_tdata_i : RUNCMD_NOOP;
            end
            if (phase == CAPTURE_PHASE) begin
                pps_now = tfio_pps_i || pps_seen;
                pending = h_mode1 || h_fwu || h_mark || h_run || (use_tfio_pps_i && pps_now);
                exp_word = expected_word(command_i, command_locked_i, h_type, h_data,
                                         h_runcmd, pending, trig_tvalid_i, trig_tdata_i,
                                         pps_now, use_tfio_pps_i);
                captures_o++;
                if (spliced_i !== exp_word) begin
                    errors_o++;
                    $display("mismatch at %0t: spliced_o %h, expected %h",
                             $time, spliced_i, exp_word);
                end
                // only sources whose field was open get acknowledged
                exp_acks = {h_mode1 && mode1_is_free(command_i, command_locked_i),
                            h_fwu && mode1_is_free(command_i, command_locked_i),
                            h_mark && mode1_is_free(command_i, command_locked_i),
                            h_run && runcmd_is_free(command_i, command_locked_i)};
                pps_seen = 1'b0;
            end else if (tfio_pps_i) begin
                pps_seen = 1'b1;
            end
            // sync makes the next cycle phase 1
            if (sync_i) begin
                phase = 1;
            end else begin
                phase = (phase + 1) % FRAME_LEN;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import rackbus_pkg::*;

    localparam int          HALF_PERIOD  = 20;
    localparam int          ACK_TIMEOUT  = 64 * FRAME_LEN;
    // cycle where sync jumps to test realignment
    localparam int          SHIFT_CYCLE  = 150;
    // start-up cycles with an unlocked remote side and no trigger or pps
    localparam int          QUIET_CYCLES = 3 * FRAME_LEN;
    localparam int          ITEMS        = 6;
    localparam logic [31:0] SEED         = 32'hdc6f47e9;

    logic                      sysclk = 1'b0;
    logic                      reset;
    // remote side is redrawn every cycle
    logic                      sync = 1'b0;
    logic [CMD_BITS-1:0]       command = '0;
    logic                      locked = 1'b0;
    logic                      trig_valid = 1'b0;
    logic [TRIG_BITS-1:0]      trig_data = '0;
    logic                      tfio_pps = 1'b0;
    logic                      use_pps = 1'b0;
    // local streams
    logic                      mode1_valid;
    logic [MODE1DATA_BITS-1:0] mode1_data;
    logic [MODE1TYPE_BITS-1:0] mode1_user;
    logic                      fw_valid;
    logic [MODE1DATA_BITS-1:0] fw_data;
    logic                      fw_mark;
    logic                      runcmd_valid;
    logic [RUNCMD_BITS-1:0]    runcmd_data;
    // DUT outputs
    logic [CMD_BITS-1:0]       spliced;
    logic                      mode1_ready;
    logic                      fw_ready;
    logic                      fw_marked;
    logic                      runcmd_ready;

    int                        errors;
    int                        captures;
    int                        timeouts = 0;
    int                        cycle = 0;
    int                        sync_cnt = 0;
    logic [31:0]               stim_rnd;

    always #HALF_PERIOD sysclk = ~sysclk;

    rackbus_splice_top UUT (
        .sysclk_i(sysclk), .reset_i(reset), .sync_i(sync),
        .command_i(command), .command_locked_i(locked),
        .mode1_tvalid_i(mode1_valid), .mode1_tdata_i(mode1_data),
        .mode1_tuser_i(mode1_user), .mode1_tready_o(mode1_ready),
        .fw_tvalid_i(fw_valid), .fw_tdata_i(fw_data), .fw_tready_o(fw_ready),
        .fw_mark_i(fw_mark), .fw_marked_o(fw_marked),
        .runcmd_tvalid_i(runcmd_valid), .runcmd_tdata_i(runcmd_data),
        .runcmd_tready_o(runcmd_ready),
        .trig_tvalid_i(trig_valid), .trig_tdata_i(trig_data),
        .tfio_pps_i(tfio_pps), .use_tfio_pps_i(use_pps),
        .spliced_o(spliced)
    );

    splice_monitor u_monitor (
        .sysclk_i(sysclk), .reset_i(reset), .sync_i(sync),
        .command_i(command), .command_locked_i(locked),
        .mode1_tvalid_i(mode1_valid), .mode1_tdata_i(mode1_data), .mode1_tuser_i(mode1_user),
        .fw_tvalid_i(fw_valid), .fw_tdata_i(fw_data), .fw_mark_i(fw_mark),
        .runcmd_tvalid_i(runcmd_valid), .runcmd_tdata_i(runcmd_data),
        .trig_tvalid_i(trig_valid), .trig_tdata_i(trig_data),
        .tfio_pps_i(tfio_pps), .use_tfio_pps_i(use_pps),
        .spliced_i(spliced), .mode1_tready_i(mode1_ready), .fw_tready_i(fw_ready),
        .fw_marked_i(fw_marked), .runcmd_tready_i(runcmd_ready),
        .errors_o(errors), .captures_o(captures)
    );

    bind cmd_splice splice_checker u_checker (
        .sysclk_i(sysclk_i), .reset_i(reset_i), .capture_i(hold_i.capture),
        .mode1_tready_i(mode1_tready_o), .fw_tready_i(fw_tready_o),
        .fw_marked_i(fw_marked_o), .runcmd_tready_i(runcmd_tready_o),
        .spliced_i(spliced_o)
    );

    // remote word with ignored, idle-mode1 and noop-runcmd cases mixed in
    function automatic logic [CMD_BITS-1:0] random_remote();
        logic [31:0]         r;
        logic [CMD_BITS-1:0] w;
        r = $urandom();
        w = $urandom();
        w[IGNORE_BIT] = (r[1:0] == 2'b00);
        if (r[2]) begin
            w[MODE1TYPE_LSB +: MODE1TYPE_BITS] = MODE1_SPECIAL;
            w[MODE1DATA_LSB +: MODE1DATA_BITS] = MODE1_NOOP;
        end
        if (r[3]) begin
            w[RUNCMD_LSB +: RUNCMD_BITS] = RUNCMD_NOOP;
        end
        return w;
    endfunction

    // remote side, trigger, pps and frame sync change on falling edges
    always @(negedge sysclk) begin
        stim_rnd = $urandom();
        command = random_remote();
        locked = stim_rnd[7:0] > 8'd24;
        trig_valid = stim_rnd[8];
        trig_data = stim_rnd[23:9];
        tfio_pps = (stim_rnd[27:24] == 4'h0);
        if (stim_rnd[31:28] == 4'h0) begin
            use_pps = ~use_pps;
        end
        // unlocked idle frames right after reset
        if (cycle < QUIET_CYCLES) begin
            locked = 1'b0;
            trig_valid = 1'b0;
            tfio_pps = 1'b0;
        end
        // one early sync pulse moves the frame
        if (cycle == SHIFT_CYCLE) begin
            sync_cnt = 3;
        end
        sync = (sync_cnt == 0);
        sync_cnt = (sync_cnt + 1) % FRAME_LEN;
        cycle++;
    end

    // src selects 0 mode1, 1 fw byte, 2 mark or 3 runcmd
    task automatic await_ack(input int src, output bit ok);
        int waited;
        bit seen;
        seen = 1'b0;
        for (waited = 0; waited < ACK_TIMEOUT && !seen; waited++) begin
            @(negedge sysclk);
            case (src)
                0: seen = mode1_ready;
                1: seen = fw_ready;
                2: seen = fw_marked;
                default: seen = runcmd_ready;
            endcase
        end
        ok = seen;
        if (!seen) begin
            timeouts++;
            $display("timeout: local source %0d was never acknowledged", src);
        end
    endtask

    task automatic send_mode1();
        logic [31:0] r;
        bit          ok;
        ok = 1'b1;
        for (int n = 0; n < ITEMS && ok; n++) begin
            r = $urandom();
            mode1_data = r[7:0];
            mode1_user = r[9:8];
            mode1_valid = 1'b1;
            await_ack(0, ok);
        end
        mode1_valid = 1'b0;
    endtask

    task automatic send_fw();
        logic [31:0] r;
        bit          ok;
        ok = 1'b1;
        for (int n = 0; n < ITEMS && ok; n++) begin
            r = $urandom();
            fw_data = r[7:0];
            fw_valid = 1'b1;
            await_ack(1, ok);
        end
        fw_valid = 1'b0;
    endtask

    task automatic request_mark();
        bit ok;
        fw_mark = 1'b1;
        await_ack(2, ok);
        fw_mark = 1'b0;
    endtask

    task automatic send_runcmd();
        logic [31:0] r;
        bit          ok;
        ok = 1'b1;
        for (int n = 0; n < ITEMS && ok; n++) begin
            r = $urandom();
            runcmd_data = r[1:0];
            runcmd_valid = 1'b1;
            await_ack(3, ok);
        end
        runcmd_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        {mode1_valid, fw_valid, fw_mark, runcmd_valid} = 4'b0000;
        mode1_data = '0;
        mode1_user = '0;
        fw_data = '0;
        runcmd_data = '0;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;
        // idle frames with nothing local
        repeat (4 * FRAME_LEN) @(negedge sysclk);
        // all sources at once so the mode1 stream wins the field first
        fork
            send_mode1();
            request_mark();
            send_fw();
            send_runcmd();
        join
        repeat (3 * FRAME_LEN) @(negedge sysclk);
        $display("errors %0d, assertion failures %0d, timeouts %0d, frames checked %0d",
                 errors, UUT.u_splice.u_checker.fail_count, timeouts, captures);
        if (errors == 0 && UUT.u_splice.u_checker.fail_count == 0 &&
            timeouts == 0 && captures > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
